// File: hdl/spi_pkg.sv
// SPI-side types only; mode encoding is {CPOL, CPHA} and the FSM state fits in 2 bits
package spi_pkg;

    // Core FSM states
    typedef enum logic [1:0] {
        SPI_IDLE = 2'd0,
        SPI_DATA = 2'd1,
        SPI_WAIT = 2'd2
    } spi_state_e;

    // Upper bit is CPOL (idle SCLK level)
    // Lower bit is CPHA, 0 samples on the first edge of a bit, 1 on the second
    typedef enum logic [1:0] {
        SPI_MODE0 = 2'b00,
        SPI_MODE1 = 2'b01,
        SPI_MODE2 = 2'b10,
        SPI_MODE3 = 2'b11
    } spi_mode_e;

    // Idle level of SCLK for a mode
    function automatic logic mode_cpol(spi_mode_e mode);
        return mode[1];
    endfunction

    // Sampling phase for a mode
    function automatic logic mode_cpha(spi_mode_e mode);
        return mode[0];
    endfunction

endpackage

// File: hdl/spi_stream_pkg.sv
// Default sizes only; the top level overrides them per instance and passes them down
package spi_stream_pkg;

    // Stream word and SPI frame word width
    localparam int DATA_WIDTH_DEF = 8;

    // Words per FIFO, need not be a power of two
    localparam int FIFO_DEPTH_DEF = 8;

    // Number of chip select lines
    localparam int SLAVE_NUM_DEF = 4;

    // Widths of the divider and frame wait inputs
    localparam int DIVIDER_WIDTH_DEF = 16;
    localparam int WAIT_WIDTH_DEF    = 16;

endpackage

// File: hdl/stream_fifo.sv
// First-word-fall-through FIFO; a write shows at the output one cycle later, no bypass path
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DATA_WIDTH = spi_stream_pkg::DATA_WIDTH_DEF,
    parameter int FIFO_DEPTH = spi_stream_pkg::FIFO_DEPTH_DEF
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  wr_valid_i,
    output logic                  wr_ready_o,
    input  logic [DATA_WIDTH-1:0] wr_data_i,
    input  logic                  wr_last_i,

    output logic                  rd_valid_o,
    input  logic                  rd_ready_i,
    output logic [DATA_WIDTH-1:0] rd_data_o,
    output logic                  rd_last_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Storage keeps the last flag next to each word
    logic [DATA_WIDTH:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                wr_fire;
    logic                rd_fire;

    assign wr_ready_o = (count != CNT_W'(FIFO_DEPTH));
    assign rd_valid_o = (count != '0);
    assign wr_fire    = wr_valid_i && wr_ready_o;
    assign rd_fire    = rd_valid_o && rd_ready_i;

    // Head word straight from the buffer
    assign rd_data_o  = mem[rd_ptr][DATA_WIDTH-1:0];
    assign rd_last_o  = mem[rd_ptr][DATA_WIDTH];

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr_last_i, wr_data_i};
        end
    end

    // Pointers wrap at FIFO_DEPTH
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_fire && !rd_fire) begin
                count <= count + 1'b1;
            end else if (rd_fire && !wr_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Write while full would push the occupancy past the depth
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count <= CNT_W'(FIFO_DEPTH));

    // Read while empty would leave the pointers out of step with the occupancy
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        int'(wr_ptr) == (int'(rd_ptr) + int'(count)) % FIFO_DEPTH);

endmodule

// File: hdl/spi_stream_master.sv
// Needs DATA_WIDTH >= 2, even clk_div_i >= 4, wait_time_i >= 1; config held stable while busy
`timescale 1ns/1ps

module spi_stream_master #(
    parameter int  DATA_WIDTH    = spi_stream_pkg::DATA_WIDTH_DEF,
    parameter int  DIVIDER_WIDTH = spi_stream_pkg::DIVIDER_WIDTH_DEF,
    parameter int  WAIT_WIDTH    = spi_stream_pkg::WAIT_WIDTH_DEF,
    parameter int  SLAVE_NUM     = spi_stream_pkg::SLAVE_NUM_DEF,
    localparam int ADDR_WIDTH    = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic [ADDR_WIDTH-1:0]    addr_i,
    input  logic [WAIT_WIDTH-1:0]    wait_time_i,
    input  logic [DIVIDER_WIDTH-1:0] clk_div_i,
    input  spi_pkg::spi_mode_e       spi_mode_i,

    input  logic                     s_valid_i,
    output logic                     s_ready_o,
    input  logic [DATA_WIDTH-1:0]    s_data_i,
    input  logic                     s_last_i,

    output logic                     m_valid_o,
    input  logic                     m_ready_i,
    output logic [DATA_WIDTH-1:0]    m_data_o,
    output logic                     m_last_o,

    output logic                     sclk_o,
    output logic                     mosi_o,
    input  logic                     miso_i,
    output logic [SLAVE_NUM-1:0]     cs_n_o
);

    // Two SCLK edges per bit
    localparam int EDGE_NUM   = 2 * DATA_WIDTH;
    localparam int EDGE_CNT_W = $clog2(EDGE_NUM + 1);

    spi_pkg::spi_state_e     state_q;

    logic                    run_q;
    logic                    cs_q;
    logic                    last_q;
    logic [1:0]              done_q;

    logic [DIVIDER_WIDTH-1:0] clk_cnt;
    logic                     half_tick;
    logic                     full_tick;
    logic [EDGE_CNT_W-1:0]    edge_cnt;
    logic                     last_edge;
    logic [WAIT_WIDTH-1:0]    wait_cnt;
    logic                     wait_done;

    logic                    sclk_q;
    logic                    mosi_q;
    logic [DATA_WIDTH-1:0]   tx_shift;
    logic [DATA_WIDTH-1:0]   rx_shift;
    logic                    launch;
    logic                    sample;

    logic                    m_valid_q;
    logic                    m_last_q;
    logic [DATA_WIDTH-1:0]   m_data_q;

    logic                    cpol;
    logic                    cpha;
    logic                    s_fire;
    logic                    m_fire;

    assign cpol = spi_pkg::mode_cpol(spi_mode_i);
    assign cpha = spi_pkg::mode_cpha(spi_mode_i);

    // No new word while a received word is still on its way out
    assign s_ready_o = run_q && (state_q == spi_pkg::SPI_IDLE) && !m_valid_q && (done_q == '0);
    assign s_fire    = s_valid_i && s_ready_o;
    assign m_fire    = m_valid_q && m_ready_i;

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    assign wait_done = (wait_cnt == wait_time_i - 1'b1);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q  <= spi_pkg::SPI_IDLE;
            run_q    <= 1'b0;
            cs_q     <= 1'b1;
            last_q   <= 1'b0;
            wait_cnt <= '0;
        end else begin
            run_q <= 1'b1;
            case (state_q)
                spi_pkg::SPI_IDLE: begin
                    if (s_fire) begin
                        state_q <= spi_pkg::SPI_DATA;
                        cs_q    <= 1'b0;
                        last_q  <= s_last_i;
                    end
                end
                spi_pkg::SPI_DATA: begin
                    if (last_edge) begin
                        cs_q     <= 1'b1;
                        wait_cnt <= '0;
                        state_q  <= last_q ? spi_pkg::SPI_WAIT : spi_pkg::SPI_IDLE;
                    end
                end
                spi_pkg::SPI_WAIT: begin
                    // Chip select stays high for the frame gap
                    if (wait_done) begin
                        state_q <= spi_pkg::SPI_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state_q <= spi_pkg::SPI_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Divider and edge counter
    // ----------------------------------------
    assign half_tick = (state_q == spi_pkg::SPI_DATA) && (clk_cnt == (clk_div_i >> 1) - 1'b1);
    assign full_tick = (state_q == spi_pkg::SPI_DATA) && (clk_cnt == clk_div_i - 1'b1);
    assign last_edge = full_tick && (edge_cnt == EDGE_CNT_W'(EDGE_NUM - 1));

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            clk_cnt  <= '0;
            edge_cnt <= '0;
            sclk_q   <= cpol;
        end else begin
            if ((state_q != spi_pkg::SPI_DATA) || full_tick) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            if (s_fire) begin
                edge_cnt <= '0;
            end else if (half_tick || full_tick) begin
                edge_cnt <= edge_cnt + 1'b1;
            end
            // SCLK follows the mode while no word is shifting
            if (state_q != spi_pkg::SPI_DATA) begin
                sclk_q <= cpol;
            end else if (half_tick || full_tick) begin
                sclk_q <= ~sclk_q;
            end
        end
    end

    assign sclk_o = sclk_q;

    // ----------------------------------------
    // Data shifters
    // ----------------------------------------

    // Leading edge is the half tick, trailing edge the full tick
    assign launch = cpha ? half_tick : full_tick;
    assign sample = cpha ? full_tick : half_tick;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mosi_q <= 1'b0;
        end else if (s_fire) begin
            // CPHA 0 needs the MSB on the line before the first edge
            if (!cpha) begin
                mosi_q <= s_data_i[DATA_WIDTH-1];
            end
        end else if (launch) begin
            mosi_q <= tx_shift[DATA_WIDTH-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_fire) begin
            tx_shift <= cpha ? s_data_i : (s_data_i << 1);
        end else if (launch) begin
            tx_shift <= tx_shift << 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample) begin
            rx_shift <= {rx_shift[DATA_WIDTH-2:0], miso_i};
        end
    end

    assign mosi_o = mosi_q;

    // Only the addressed slave sees the active chip select
    always_comb begin
        for (int i = 0; i < SLAVE_NUM; i++) begin
            cs_n_o[i] = cs_q || (addr_i != ADDR_WIDTH'(i));
        end
    end

    // ----------------------------------------
    // Output stream register
    // ----------------------------------------

    // Word leaves two cycles after chip select rises
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            done_q    <= '0;
            m_valid_q <= 1'b0;
            m_last_q  <= 1'b0;
        end else begin
            done_q <= {done_q[0], last_edge};
            if (done_q[1]) begin
                m_valid_q <= 1'b1;
                m_last_q  <= last_q;
            end else if (m_fire) begin
                m_valid_q <= 1'b0;
                m_last_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_q[1]) begin
            m_data_q <= rx_shift;
        end
    end

    assign m_valid_o = m_valid_q;
    assign m_data_o  = m_data_q;
    assign m_last_o  = m_last_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Chip select is active only while a word is shifting
    a_cs_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(~cs_n_o) && (cs_q == (state_q != spi_pkg::SPI_DATA)));

    // Allow one cycle for SCLK to follow a mode change
    a_sclk_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ((&cs_n_o) && $stable(spi_mode_i)) |-> (sclk_o == cpol));

    // A new word is only taken while the bus is quiet
    a_accept_start: assert property (@(posedge clk_i) disable iff (!rstn_i)
        s_ready_o |-> ((state_q == spi_pkg::SPI_IDLE) && cs_q && (clk_cnt == '0)));

endmodule

// File: hdl/spi_stream_top.sv
// Stream-fed SPI master; config inputs are plain levels and must not change while busy
`timescale 1ns/1ps

module spi_stream_top #(
    parameter int  DATA_WIDTH    = spi_stream_pkg::DATA_WIDTH_DEF,
    parameter int  FIFO_DEPTH    = spi_stream_pkg::FIFO_DEPTH_DEF,
    parameter int  SLAVE_NUM     = spi_stream_pkg::SLAVE_NUM_DEF,
    parameter int  DIVIDER_WIDTH = spi_stream_pkg::DIVIDER_WIDTH_DEF,
    parameter int  WAIT_WIDTH    = spi_stream_pkg::WAIT_WIDTH_DEF,
    localparam int ADDR_WIDTH    = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,

    input  logic [ADDR_WIDTH-1:0]    addr_i,
    input  logic [WAIT_WIDTH-1:0]    wait_time_i,
    input  logic [DIVIDER_WIDTH-1:0] clk_div_i,
    input  spi_pkg::spi_mode_e       spi_mode_i,

    input  logic                     s_valid_i,
    output logic                     s_ready_o,
    input  logic [DATA_WIDTH-1:0]    s_data_i,
    input  logic                     s_last_i,

    output logic                     m_valid_o,
    input  logic                     m_ready_i,
    output logic [DATA_WIDTH-1:0]    m_data_o,
    output logic                     m_last_o,

    output logic                     sclk_o,
    output logic                     mosi_o,
    input  logic                     miso_i,
    output logic [SLAVE_NUM-1:0]     cs_n_o
);

    // Transmit FIFO to core
    logic                  tx_valid;
    logic                  tx_ready;
    logic [DATA_WIDTH-1:0] tx_data;
    logic                  tx_last;

    // Core to receive FIFO
    logic                  rx_valid;
    logic                  rx_ready;
    logic [DATA_WIDTH-1:0] rx_data;
    logic                  rx_last;

    stream_fifo #(
        .DATA_WIDTH(DATA_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_tx_fifo (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wr_valid_i(s_valid_i),
        .wr_ready_o(s_ready_o),
        .wr_data_i (s_data_i),
        .wr_last_i (s_last_i),
        .rd_valid_o(tx_valid),
        .rd_ready_i(tx_ready),
        .rd_data_o (tx_data),
        .rd_last_o (tx_last)
    );

    spi_stream_master #(
        .DATA_WIDTH   (DATA_WIDTH),
        .DIVIDER_WIDTH(DIVIDER_WIDTH),
        .WAIT_WIDTH   (WAIT_WIDTH),
        .SLAVE_NUM    (SLAVE_NUM)
    ) u_master (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .addr_i     (addr_i),
        .wait_time_i(wait_time_i),
        .clk_div_i  (clk_div_i),
        .spi_mode_i (spi_mode_i),
        .s_valid_i  (tx_valid),
        .s_ready_o  (tx_ready),
        .s_data_i   (tx_data),
        .s_last_i   (tx_last),
        .m_valid_o  (rx_valid),
        .m_ready_i  (rx_ready),
        .m_data_o   (rx_data),
        .m_last_o   (rx_last),
        .sclk_o     (sclk_o),
        .mosi_o     (mosi_o),
        .miso_i     (miso_i),
        .cs_n_o     (cs_n_o)
    );

    stream_fifo #(
        .DATA_WIDTH(DATA_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .wr_valid_i(rx_valid),
        .wr_ready_o(rx_ready),
        .wr_data_i (rx_data),
        .wr_last_i (rx_last),
        .rd_valid_o(m_valid_o),
        .rd_ready_i(m_ready_i),
        .rd_data_o (m_data_o),
        .rd_last_o (m_last_o)
    );

endmodule

// File: dv/spi_stream_checker.sv
// Observes pins one clock late, so config inputs must only change while the DUT is idle
`timescale 1ns/1ps

module spi_stream_checker #(
    parameter int DATA_WIDTH    = spi_stream_pkg::DATA_WIDTH_DEF,
    parameter int SLAVE_NUM     = spi_stream_pkg::SLAVE_NUM_DEF,
    parameter int DIVIDER_WIDTH = spi_stream_pkg::DIVIDER_WIDTH_DEF,
    parameter int WAIT_WIDTH    = spi_stream_pkg::WAIT_WIDTH_DEF,
    parameter int ADDR_WIDTH    = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic [ADDR_WIDTH-1:0]    addr_i,
    input  logic [WAIT_WIDTH-1:0]    wait_time_i,
    input  logic [DIVIDER_WIDTH-1:0] clk_div_i,
    input  spi_pkg::spi_mode_e       spi_mode_i,
    input  logic                     s_valid_i,
    input  logic                     s_ready_i,
    input  logic [DATA_WIDTH-1:0]    s_data_i,
    input  logic                     s_last_i,
    input  logic                     m_valid_i,
    input  logic                     m_ready_i,
    input  logic [DATA_WIDTH-1:0]    m_data_i,
    input  logic                     m_last_i,
    input  logic                     sclk_i,
    input  logic                     mosi_i,
    input  logic                     miso_i,
    input  logic [SLAVE_NUM-1:0]     cs_n_i,
    output int                       error_count_o,
    output int                       word_count_o
);

    // Accepted input words and words expected at the output, {last, data}
    logic [DATA_WIDTH:0]   in_q[$];
    logic [DATA_WIDTH:0]   rx_q[$];
    logic [DATA_WIDTH:0]   exp;
    logic [DATA_WIDTH-1:0] mosi_sh;
    logic [DATA_WIDTH-1:0] miso_sh;
    logic                  prev_sclk;
    logic                  prev_active;
    logic                  active;
    logic                  leading;
    logic                  gap_armed;
    spi_pkg::spi_mode_e    prev_mode;
    int                    tick_cnt;
    int                    edge_cnt;
    int                    gap_cnt;

    initial begin
        error_count_o = 0;
        word_count_o  = 0;
    end

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            prev_sclk   = sclk_i;
            prev_active = 1'b0;
            prev_mode   = spi_mode_i;
            gap_armed   = 1'b0;
            gap_cnt     = 0;
        end else begin
            active = !(&cs_n_i);
            if (s_valid_i && s_ready_i) begin
                in_q.push_back({s_last_i, s_data_i});
            end
            // ----------------------------------------
            // Output stream
            // ----------------------------------------
            if (m_valid_i && m_ready_i) begin
                if (rx_q.size() == 0) begin
                    $display("Output word appeared with no transfer behind it at %0t", $time);
                    error_count_o++;
                end else begin
                    exp = rx_q.pop_front();
                    word_count_o++;
                    if (m_data_i !== exp[DATA_WIDTH-1:0]) begin
                        $display("[FAIL] %0t m_data_o expected %h got %h",
                                 $time, exp[DATA_WIDTH-1:0], m_data_i);
                        error_count_o++;
                    end
                    if (m_last_i !== exp[DATA_WIDTH]) begin
                        $display("[FAIL] %0t m_last_o expected %b got %b",
                                 $time, exp[DATA_WIDTH], m_last_i);
                        error_count_o++;
                    end
                end
            end
            // Chip select decode and idle clock level
            if (active) begin
                if (cs_n_i !== ~(SLAVE_NUM'(1) << addr_i)) begin
                    $display("[FAIL] %0t cs_n_o expected %b got %b",
                             $time, ~(SLAVE_NUM'(1) << addr_i), cs_n_i);
                    error_count_o++;
                end
            end else if (spi_mode_i == prev_mode && sclk_i !== spi_mode_i[1]) begin
                $display("[FAIL] %0t sclk_o expected %b got %b", $time, spi_mode_i[1], sclk_i);
                error_count_o++;
            end
            // ----------------------------------------
            // SCLK edges and bit sampling
            // ----------------------------------------
            if (active && !prev_active) begin
                if (gap_armed && gap_cnt < int'(wait_time_i)) begin
                    $display("Frame gap of %0d cycles is shorter than wait time %0d at %0t",
                             gap_cnt, wait_time_i, $time);
                    error_count_o++;
                end
                gap_armed = 1'b0;
                tick_cnt  = 0;
                edge_cnt  = 0;
            end else if (active || prev_active) begin
                tick_cnt++;
                if (sclk_i !== prev_sclk) begin
                    if (tick_cnt != int'(clk_div_i) / 2) begin
                        $display("[FAIL] %0t sclk_half_period expected %0d got %0d",
                                 $time, clk_div_i / 2, tick_cnt);
                        error_count_o++;
                    end
                    tick_cnt = 0;
                    edge_cnt++;
                    leading  = (prev_sclk == spi_mode_i[1]);
                    if (leading ^ spi_mode_i[0]) begin
                        mosi_sh = {mosi_sh[DATA_WIDTH-2:0], mosi_i};
                        miso_sh = {miso_sh[DATA_WIDTH-2:0], miso_i};
                    end
                end
            end
            // End of a word
            if (!active && prev_active) begin
                if (edge_cnt != 2 * DATA_WIDTH) begin
                    $display("[FAIL] %0t sclk_edges expected %0d got %0d",
                             $time, 2 * DATA_WIDTH, edge_cnt);
                    error_count_o++;
                end
                if (in_q.size() == 0) begin
                    $display("SPI transfer ran with no accepted input word at %0t", $time);
                    error_count_o++;
                end else begin
                    exp = in_q.pop_front();
                    if (mosi_sh !== exp[DATA_WIDTH-1:0]) begin
                        $display("[FAIL] %0t mosi_o expected %h got %h",
                                 $time, exp[DATA_WIDTH-1:0], mosi_sh);
                        error_count_o++;
                    end
                    rx_q.push_back({exp[DATA_WIDTH], miso_sh});
                    gap_armed = exp[DATA_WIDTH];
                    gap_cnt   = 0;
                end
            end
            if (!active) begin
                gap_cnt++;
            end
            prev_sclk   = sclk_i;
            prev_active = active;
            prev_mode   = spi_mode_i;
        end
    end

endmodule

// File: dv/tb_spi_stream_top.sv
// Random frames in all SPI modes with a behavioral slave; seed fixed at 70, all waits bounded
`timescale 1ns/1ps

module tb_spi_stream_top;

    localparam int DW = spi_stream_pkg::DATA_WIDTH_DEF;
    localparam int SN = spi_stream_pkg::SLAVE_NUM_DEF;
    localparam int AW = (SN > 1) ? $clog2(SN) : 1;

    logic                clk_i;
    logic                rstn_i;
    logic [AW-1:0]       addr_i;
    logic [15:0]         wait_time_i;
    logic [15:0]         clk_div_i;
    spi_pkg::spi_mode_e  spi_mode_i;
    logic                s_valid_i;
    logic                s_ready_o;
    logic [DW-1:0]       s_data_i;
    logic                s_last_i;
    logic                m_valid_o;
    logic                m_ready_i;
    logic [DW-1:0]       m_data_o;
    logic                m_last_o;
    logic                sclk_o;
    logic                mosi_o;
    logic                miso_i;
    logic [SN-1:0]       cs_n_o;

    int                  chk_errors;
    int                  chk_words;
    int                  tb_errors;
    int                  sent_count;
    logic                hold_low;
    logic                ready_dropped;

    // Slave state
    logic [DW-1:0]       slave_byte;
    int                  slave_idx;
    logic                slave_prev_sclk;
    logic                slave_prev_cs;

    spi_stream_top u_dut (.*);

    spi_stream_checker u_checker (
        .clk_i(clk_i), .rstn_i(rstn_i), .addr_i(addr_i), .wait_time_i(wait_time_i),
        .clk_div_i(clk_div_i), .spi_mode_i(spi_mode_i), .s_valid_i(s_valid_i),
        .s_ready_i(s_ready_o), .s_data_i(s_data_i), .s_last_i(s_last_i),
        .m_valid_i(m_valid_o), .m_ready_i(m_ready_i), .m_data_i(m_data_o),
        .m_last_i(m_last_o), .sclk_i(sclk_o), .mosi_i(mosi_o), .miso_i(miso_i),
        .cs_n_i(cs_n_o), .error_count_o(chk_errors), .word_count_o(chk_words)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Output ready, random unless held low
    always @(posedge clk_i) begin
        #1;
        m_ready_i = hold_low ? 1'b0 : ($urandom % 4 != 0);
        if (hold_low && !s_ready_o) begin
            ready_dropped = 1'b1;
        end
    end

    // ----------------------------------------
    // Behavioral SPI slave, MSB first
    // ----------------------------------------
    always @(posedge clk_i) begin
        #1;
        if (!rstn_i) begin
            miso_i = 1'b0;
        end else if (!(&cs_n_o) && slave_prev_cs) begin
            slave_byte = DW'($urandom);
            slave_idx  = DW - 1;
            if (!spi_mode_i[0]) begin
                miso_i = slave_byte[slave_idx];
                slave_idx--;
            end
        end else if (!(&cs_n_o) && sclk_o != slave_prev_sclk) begin
            // Drive on the edge opposite to sampling
            if (((slave_prev_sclk == spi_mode_i[1]) == spi_mode_i[0]) && slave_idx >= 0) begin
                miso_i = slave_byte[slave_idx];
                slave_idx--;
            end
        end
        slave_prev_sclk = sclk_o;
        slave_prev_cs   = &cs_n_o;
    end

    task automatic fail_now(input string why);
        $display("%s at %0t", why, $time);
        $display("Test failed");
        $finish;
    endtask

    task automatic send_byte(input logic [DW-1:0] data, input logic last);
        int cycles;
        cycles      = 0;
        s_valid_i   = 1'b1;
        s_data_i    = data;
        s_last_i    = last;
        forever begin
            @(posedge clk_i);
            if (s_ready_o) break;
            cycles++;
            if (cycles > 6000) fail_now("Input stream stalled too long");
        end
        #1;
        s_valid_i  = 1'b0;
        sent_count++;
    endtask

    // Idle means the output FIFO empty and chip select high for a while
    task automatic wait_idle();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < 16) begin
            @(posedge clk_i);
            if (!m_valid_o && (&cs_n_o) && s_ready_o) quiet++;
            else quiet = 0;
            cycles++;
            if (cycles > 20000) fail_now("DUT did not return to idle");
        end
        #1;
    endtask

    task automatic send_frames(input int frames);
        int n;
        for (int f = 0; f < frames; f++) begin
            n = 1 + $urandom % 4;
            for (int b = 0; b < n; b++) begin
                send_byte(DW'($urandom), b == n - 1);
            end
        end
    endtask

    initial begin
        void'($urandom(70));
        rstn_i        = 1'b0;
        addr_i        = '0;
        wait_time_i   = 16'd1;
        clk_div_i     = 16'd4;
        spi_mode_i    = spi_pkg::SPI_MODE0;
        s_valid_i     = 1'b0;
        s_data_i      = '0;
        s_last_i      = 1'b0;
        m_ready_i     = 1'b0;
        miso_i        = 1'b0;
        hold_low      = 1'b0;
        ready_dropped = 1'b0;
        tb_errors     = 0;
        sent_count    = 0;
        repeat (10) @(posedge clk_i);
        #1 rstn_i = 1'b1;
        for (int blk = 0; blk < 12; blk++) begin
            wait_idle();
            spi_mode_i  = spi_pkg::spi_mode_e'(blk % 4);
            addr_i      = AW'($urandom);
            clk_div_i   = 16'(4 + 2 * ($urandom % 3));
            wait_time_i = 16'(1 + $urandom % 6);
            if (blk == 6) begin
                // Long back-pressure stretch
                hold_low = 1'b1;
                fork
                    send_frames(10);
                    begin
                        repeat (3000) @(posedge clk_i);
                        hold_low = 1'b0;
                    end
                join
                if (!ready_dropped) begin
                    $display("Input ready never dropped under output back-pressure");
                    tb_errors++;
                end
            end else begin
                send_frames(3);
            end
        end
        wait_idle();
        if (chk_words != sent_count) begin
            $display("Sent %0d words but received %0d", sent_count, chk_words);
            tb_errors++;
        end
        $display("Errors: checker %0d, testbench %0d; words %0d of %0d",
                 chk_errors, tb_errors, chk_words, sent_count);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: spi_stream_top.f
hdl/spi_pkg.sv
hdl/spi_stream_pkg.sv
hdl/stream_fifo.sv
hdl/spi_stream_master.sv
hdl/spi_stream_top.sv
dv/spi_stream_checker.sv
dv/tb_spi_stream_top.sv

// File: Bender.yml
package:
  name: spi_stream

sources:
  - files:
      - hdl/spi_pkg.sv
      - hdl/spi_stream_pkg.sv
      - hdl/stream_fifo.sv
      - hdl/spi_stream_master.sv
      - hdl/spi_stream_top.sv
  - target: test
    files:
      - dv/spi_stream_checker.sv
      - dv/tb_spi_stream_top.sv
